// File: lsu.f
+incdir+.
lsu_pkg.sv
mem_op_decode.sv
mem_access_fsm.sv
load_format.sv
data_ram.sv
lsu_top.sv
lsu_checker.sv
lsu_monitor.sv
lsu_tb.sv

// File: Makefile
# Verilator build and run for the memory-stage testbench

VERILATOR ?= verilator
TOP       ?= lsu_tb
FLIST     ?= lsu.f
VFLAGS    ?= --binary --timing --assert
OBJDIR    ?= obj_dir
RUNFLAGS  ?= +verilator+error+limit+100

BIN := $(OBJDIR)/V$(TOP)

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

run: compile
	@out="$$(./$(BIN) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf $(OBJDIR)

// File: lsu_tb.sv
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_tb
    import lsu_pkg::*;
();

    localparam int WAIT_LIMIT   = 60;
    localparam int RAND_ENTRIES = 20;

    typedef struct packed {
        mem_op_t              op;
        logic [`LSU_XLEN-1:0] addr;
        logic [`LSU_XLEN-1:0] rs2;
        logic                 flush;
        logic                 check;
        logic [`LSU_XLEN-1:0] exp_data;
    } entry_t;

    logic        clk;
    logic        reset;
    stage_in_t   stage_in;
    logic        pipeline_flush;
    mem_wb_t     mem_wb;
    logic        memory_unit_stall;

    entry_t      table_q[$];
    logic [31:0] lcg_state;
    logic [63:0] next_id;
    int          table_errors;
    int          timeouts;
    int          loads_applied;
    int          monitor_errors;
    int          loads_checked;
    int          assert_fails;

    lsu_top lsu_top_inst (
        .clk               (clk),
        .reset             (reset),
        .stage_in          (stage_in),
        .pipeline_flush    (pipeline_flush),
        .mem_wb            (mem_wb),
        .memory_unit_stall (memory_unit_stall)
    );

    lsu_monitor lsu_monitor_inst (
        .clk               (clk),
        .reset             (reset),
        .stage_in          (stage_in),
        .mem_wb            (mem_wb),
        .memory_unit_stall (memory_unit_stall),
        .dreq              (lsu_top_inst.dreq),
        .req_ready         (lsu_top_inst.req_ready),
        .error_count       (monitor_errors),
        .loads_checked     (loads_checked)
    );

    bind mem_access_fsm lsu_checker lsu_checker_inst (
        .clk               (clk),
        .reset             (reset),
        .pipeline_flush    (pipeline_flush),
        .dreq              (dreq),
        .req_ready         (req_ready),
        .dresp             (dresp),
        .eff_op            (eff_op),
        .memory_unit_stall (memory_unit_stall)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic is_load_op(mem_op_t op);
        return op inside {MEN_LB, MEN_LBU, MEN_LH, MEN_LHU, MEN_LW, MEN_AMOSWAP};
    endfunction

    task automatic add_entry(input mem_op_t op, input logic [31:0] addr, input logic [31:0] rs2,
                             input logic flush, input logic check, input logic [31:0] exp_data);
        entry_t e;
        e = '{op, addr, rs2, flush, check, exp_data};
        table_q.push_back(e);
    endtask

    task automatic build_table();
        logic [31:0] r;
        mem_op_t     op;
        add_entry(MEN_SW,      32'h10, 32'h1234_5678, 1'b0, 1'b0, 32'h0);
        add_entry(MEN_LW,      32'h10, 32'h0,         1'b0, 1'b1, 32'h1234_5678);
        // narrow stores merge into the low lanes only
        add_entry(MEN_SW,      32'h20, 32'ha5a5_a5a5, 1'b0, 1'b0, 32'h0);
        add_entry(MEN_SB,      32'h20, 32'hffff_ff3c, 1'b0, 1'b0, 32'h0);
        add_entry(MEN_LW,      32'h20, 32'h0,         1'b0, 1'b1, 32'ha5a5_a53c);
        add_entry(MEN_SH,      32'h20, 32'h0000_beef, 1'b0, 1'b0, 32'h0);
        add_entry(MEN_LW,      32'h20, 32'h0,         1'b0, 1'b1, 32'ha5a5_beef);
        add_entry(MEN_SW,      32'h30, 32'h8765_80f1, 1'b0, 1'b0, 32'h0);
        add_entry(MEN_LB,      32'h30, 32'h0,         1'b0, 1'b1, 32'hffff_fff1);
        add_entry(MEN_LBU,     32'h30, 32'h0,         1'b0, 1'b1, 32'h0000_00f1);
        add_entry(MEN_LH,      32'h30, 32'h0,         1'b0, 1'b1, 32'hffff_80f1);
        add_entry(MEN_LHU,     32'h30, 32'h0,         1'b0, 1'b1, 32'h0000_80f1);
        add_entry(MEN_AMOSWAP, 32'h10, 32'hcafe_f00d, 1'b0, 1'b1, 32'h1234_5678);
        add_entry(MEN_LW,      32'h10, 32'h0,         1'b0, 1'b1, 32'hcafe_f00d);
        add_entry(MEN_X,       32'h44, 32'h5555_aaaa, 1'b0, 1'b0, 32'h0);
        // flushed load whose late response must not reach the next load
        add_entry(MEN_LW,      32'h30, 32'h0,         1'b1, 1'b0, 32'h0);
        add_entry(MEN_LW,      32'h40, 32'h0,         1'b0, 1'b1, 32'h0);
        for (int i = 0; i < RAND_ENTRIES; i++) begin
            r = next_rand();
            case (r[18:16])
                3'd0:    op = MEN_SW;
                3'd1:    op = MEN_SB;
                3'd2:    op = MEN_LB;
                3'd3:    op = MEN_LBU;
                default: op = MEN_LW;
            endcase
            add_entry(op, {26'd0, r[3:0], 2'b00}, next_rand(), 1'b0, 1'b0, 32'h0);
        end
    endtask

    task automatic check_result(input entry_t e, input int waited);
        if (mem_wb.valid !== 1'b1 || mem_wb.reg_pc !== stage_in.reg_pc ||
            mem_wb.inst !== stage_in.inst || mem_wb.inst_id !== stage_in.inst_id ||
            mem_wb.ctrl !== stage_in.ctrl || mem_wb.alu_out !== stage_in.alu_out ||
            mem_wb.csr_rdata !== stage_in.csr_rdata) begin
            $display("error %0t: write-back fields differ from inputs, inst_id %0d",
                $time, next_id);
            table_errors++;
        end
        if (e.op == MEN_X && waited != 1) begin
            $display("error %0t: stall raised for a non-memory op", $time);
            table_errors++;
        end
        if (e.check && mem_wb.mem_rdata !== e.exp_data) begin
            $display("error %0t: %s at %h read %h, expected %h", $time, e.op.name(),
                e.addr, mem_wb.mem_rdata, e.exp_data);
            table_errors++;
        end
    endtask

    task automatic apply_entry(input entry_t e, output logic stuck);
        int waited;
        @(negedge clk);
        next_id                 = next_id + 64'd1;
        stage_in.valid          = 1'b1;
        stage_in.reg_pc         = 32'h0000_2000 + {next_id[29:0], 2'b00};
        stage_in.inst           = {next_id[15:0], 16'h2083};
        stage_in.inst_id        = next_id;
        stage_in.ctrl.mem_op    = e.op;
        stage_in.ctrl.rs2_data  = e.rs2;
        stage_in.alu_out        = e.addr;
        stage_in.csr_rdata      = ~e.addr;
        pipeline_flush          = 1'b0;
        stuck                   = 1'b0;
        if (e.flush) begin
            // flush raised in the cycle the memory accepts the request
            @(negedge clk);
            pipeline_flush = 1'b1;
            @(posedge clk);
            if (mem_wb.valid !== 1'b0) begin
                $display("error %0t: flushed entry reached write-back", $time);
                table_errors++;
            end
        end else begin
            if (is_load_op(e.op)) begin
                loads_applied++;
            end
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (memory_unit_stall && waited < WAIT_LIMIT);
            if (memory_unit_stall) begin
                $display("timeout: stall stayed high for inst_id %0d", next_id);
                timeouts++;
                stuck = 1'b1;
            end else begin
                check_result(e, waited);
            end
        end
    endtask

    initial begin
        logic stuck;
        reset          = 1'b1;
        pipeline_flush = 1'b0;
        stage_in       = '0;
        // non-memory op held through reset so stall shows the reset state
        stage_in.valid = 1'b1;
        lcg_state      = 32'h3b46_a27f;
        next_id        = 64'd0;
        table_errors   = 0;
        timeouts       = 0;
        loads_applied  = 0;
        stuck          = 1'b0;
        build_table();
        repeat (4) @(negedge clk);
        reset = 1'b0;
        foreach (table_q[i]) begin
            if (!stuck) begin
                apply_entry(table_q[i], stuck);
            end
        end
        // let the monitor see the last completion
        @(negedge clk);
        stage_in.valid = 1'b0;
        repeat (2) @(negedge clk);
        if (loads_checked != loads_applied) begin
            $display("monitor compared %0d loads but %0d were applied",
                loads_checked, loads_applied);
            table_errors++;
        end
        assert_fails = lsu_top_inst.mem_access_fsm_inst.lsu_checker_inst.fail_count;
        $display("summary: %0d table errors, %0d monitor errors, %0d assertion failures, %0d timeouts",
            table_errors, monitor_errors, assert_fails, timeouts);
        if (table_errors + monitor_errors + assert_fails + timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: lsu_monitor.sv
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_monitor
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  stage_in_t stage_in,
    input  mem_wb_t   mem_wb,
    input  logic      memory_unit_stall,
    input  dreq_t     dreq,
    input  logic      req_ready,
    output int        error_count,
    output int        loads_checked
);

    localparam int IDX_W = $clog2(`LSU_RAM_WORDS);

    logic [`LSU_XLEN-1:0] shadow [`LSU_RAM_WORDS];
    logic [`LSU_XLEN-1:0] read_word;
    logic [`LSU_XLEN-1:0] mask;
    logic [IDX_W-1:0]     idx;
    logic [63:0]          cur_id;
    logic [63:0]          done_id;
    mem_op_t              op;
    int                   xfers;

    function automatic logic [`LSU_XLEN-1:0] expected_load(mem_op_t o, logic [`LSU_XLEN-1:0] w);
        case (o)
            MEN_LB:  return {{(`LSU_XLEN-8){w[7]}}, w[7:0]};
            MEN_LBU: return {{(`LSU_XLEN-8){1'b0}}, w[7:0]};
            MEN_LH:  return {{(`LSU_XLEN-16){w[15]}}, w[15:0]};
            MEN_LHU: return {{(`LSU_XLEN-16){1'b0}}, w[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic logic [`LSU_XLEN-1:0] store_mask(mem_op_t o);
        case (o)
            MEN_SB:  return 32'h0000_00ff;
            MEN_SH:  return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    function automatic logic is_read_op(mem_op_t o);
        return o inside {MEN_LB, MEN_LBU, MEN_LH, MEN_LHU, MEN_LW, MEN_AMOSWAP};
    endfunction

    // swap writes on its second transfer
    function automatic logic write_expected(mem_op_t o, int done_xfers);
        if (o == MEN_AMOSWAP) begin
            return done_xfers == 1;
        end
        return o inside {MEN_SB, MEN_SH, MEN_SW};
    endfunction

    function automatic int xfers_needed(mem_op_t o);
        if (o == MEN_AMOSWAP) begin
            return 2;
        end
        return (o == MEN_X) ? 0 : 1;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("error %0t: %s", $time, msg);
        error_count++;
    endtask

    always @(posedge clk) begin
        op = stage_in.ctrl.mem_op;
        if (reset) begin
            for (int i = 0; i < `LSU_RAM_WORDS; i++) begin
                shadow[i] = '0;
            end
            read_word     = '0;
            cur_id        = '1;
            done_id       = '1;
            xfers         = 0;
            error_count   = 0;
            loads_checked = 0;
        end else begin
            if (stage_in.inst_id != cur_id) begin
                cur_id = stage_in.inst_id;
                xfers  = 0;
            end
            if (dreq.valid && req_ready) begin
                idx = dreq.addr[IDX_W+1:2];
                if (stage_in.inst_id == done_id) begin
                    report_mismatch($sformatf("request again for done inst_id %0d", done_id));
                end
                if (dreq.addr !== stage_in.alu_out || dreq.wen !== write_expected(op, xfers)) begin
                    report_mismatch($sformatf("request addr %h wen %b for op %s",
                        dreq.addr, dreq.wen, op.name()));
                end
                if (dreq.wen) begin
                    mask = store_mask(op);
                    if (dreq.wmask !== mask || dreq.wdata !== stage_in.ctrl.rs2_data) begin
                        report_mismatch($sformatf("store data %h mask %h, expected %h mask %h",
                            dreq.wdata, dreq.wmask, stage_in.ctrl.rs2_data, mask));
                    end
                    shadow[idx] = (shadow[idx] & ~mask) | (stage_in.ctrl.rs2_data & mask);
                end else begin
                    read_word = shadow[idx];
                end
                xfers++;
            end
            // first cycle with stall low marks completion
            if (mem_wb.valid && !memory_unit_stall && op != MEN_X &&
                stage_in.inst_id != done_id) begin
                done_id = stage_in.inst_id;
                if (xfers != xfers_needed(op)) begin
                    report_mismatch($sformatf("inst_id %0d made %0d transfers", done_id, xfers));
                end
                if (is_read_op(op)) begin
                    loads_checked++;
                    if (mem_wb.mem_rdata !== expected_load(op, read_word)) begin
                        report_mismatch($sformatf("%s read %h, expected %h", op.name(),
                            mem_wb.mem_rdata, expected_load(op, read_word)));
                    end
                end
            end
        end
    end

endmodule

// File: lsu_checker.sv
`timescale 1ns/10ps

module lsu_checker
    import lsu_pkg::*;
(
    input logic    clk,
    input logic    reset,
    input logic    pipeline_flush,
    input dreq_t   dreq,
    input logic    req_ready,
    input dresp_t  dresp,
    input mem_op_t eff_op,
    input logic    memory_unit_stall
);

    int   fail_count = 0;
    logic read_open;

    // one read may be in flight between transfer and response
    always_ff @(posedge clk) begin
        if (reset) begin
            read_open <= 1'b0;
        end else if (dreq.valid && req_ready && !dreq.wen) begin
            read_open <= 1'b1;
        end else if (dresp.valid) begin
            read_open <= 1'b0;
        end
    end

    req_held: assert property (@(posedge clk) disable iff (reset)
        (dreq.valid && !req_ready && !pipeline_flush) |=> $stable(dreq))
    else begin
        fail_count++;
        $error("request fields changed while waiting for ready");
    end

    resp_has_read: assert property (@(posedge clk) disable iff (reset)
        dresp.valid |-> read_open)
    else begin
        fail_count++;
        $error("response without an outstanding read");
    end

    // out of reset the machine idles in WAIT
    stall_after_reset: assert property (@(posedge clk)
        reset |=> (!memory_unit_stall || eff_op != MEN_X))
    else begin
        fail_count++;
        $error("stall high right after reset");
    end

endmodule

// File: lsu_top.sv
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_top
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  stage_in_t stage_in,
    input  logic      pipeline_flush,
    output mem_wb_t   mem_wb,
    output logic      memory_unit_stall
);

    mem_op_t              eff_op;
    op_info_t             info;
    dreq_t                dreq;
    dresp_t               dresp;
    logic                 req_ready;
    logic [`LSU_XLEN-1:0] rdata_held;
    logic [`LSU_XLEN-1:0] load_data;

    mem_op_decode mem_op_decode_inst (
        .op   (eff_op),
        .info (info)
    );

    mem_access_fsm mem_access_fsm_inst (
        .clk               (clk),
        .reset             (reset),
        .pipeline_flush    (pipeline_flush),
        .stage_in          (stage_in),
        .info              (info),
        .req_ready         (req_ready),
        .dresp             (dresp),
        .eff_op            (eff_op),
        .dreq              (dreq),
        .rdata_held        (rdata_held),
        .memory_unit_stall (memory_unit_stall)
    );

    // formatted by the instruction's own op, not the swap's store half
    load_format load_format_inst (
        .op   (stage_in.ctrl.mem_op),
        .raw  (rdata_held),
        .data (load_data)
    );

    data_ram data_ram_inst (
        .clk       (clk),
        .reset     (reset),
        .dreq      (dreq),
        .req_ready (req_ready),
        .dresp     (dresp)
    );

    assign mem_wb.valid     = stage_in.valid && !pipeline_flush;
    assign mem_wb.reg_pc    = stage_in.reg_pc;
    assign mem_wb.inst      = stage_in.inst;
    assign mem_wb.inst_id   = stage_in.inst_id;
    assign mem_wb.ctrl      = stage_in.ctrl;
    assign mem_wb.alu_out   = stage_in.alu_out;
    assign mem_wb.mem_rdata = load_data;
    assign mem_wb.csr_rdata = stage_in.csr_rdata;

endmodule

// File: data_ram.sv
`timescale 1ns/10ps
`include "lsu_config.svh"

module data_ram
    import lsu_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  dreq_t  dreq,
    output logic   req_ready,
    output dresp_t dresp
);

    localparam int IDX_W = $clog2(`LSU_RAM_WORDS);
    localparam int CNT_W = $clog2(`LSU_RAM_LATENCY + 1);

    logic [`LSU_XLEN-1:0] mem [`LSU_RAM_WORDS];
    logic [IDX_W-1:0]     idx;
    logic                 xfer;
    logic                 pending;
    logic [CNT_W-1:0]     cnt;
    logic [`LSU_XLEN-1:0] rdata_q;

    // word index, byte offset bits dropped
    assign idx  = dreq.addr[IDX_W+1:2];
    assign xfer = dreq.valid && req_ready;

    // one read in flight at a time
    assign req_ready = !pending;

    assign dresp.valid = pending && (cnt == '0);
    assign dresp.rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            cnt     <= '0;
            for (int i = 0; i < `LSU_RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (xfer && dreq.wen) begin
                mem[idx] <= (mem[idx] & ~dreq.wmask) | (dreq.wdata & dreq.wmask);
            end else if (xfer) begin
                pending <= 1'b1;
                cnt     <= CNT_W'(`LSU_RAM_LATENCY - 1);
            end else if (pending) begin
                if (cnt == '0) begin
                    pending <= 1'b0;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    // word sampled at the read transfer
    always_ff @(posedge clk) begin
        if (xfer && !dreq.wen) begin
            rdata_q <= mem[idx];
        end
    end

endmodule

// File: load_format.sv
`timescale 1ns/10ps
`include "lsu_config.svh"

module load_format
    import lsu_pkg::*;
(
    input  mem_op_t              op,
    input  logic [`LSU_XLEN-1:0] raw,
    output logic [`LSU_XLEN-1:0] data
);

    always_comb begin
        case (op)
            MEN_LB: begin
                data = {{(`LSU_XLEN-8){raw[7]}}, raw[7:0]};
            end
            MEN_LBU: begin
                data = {{(`LSU_XLEN-8){1'b0}}, raw[7:0]};
            end
            MEN_LH: begin
                data = {{(`LSU_XLEN-16){raw[15]}}, raw[15:0]};
            end
            MEN_LHU: begin
                data = {{(`LSU_XLEN-16){1'b0}}, raw[15:0]};
            end
            // word loads and the swap's old value pass unchanged
            default: begin
                data = raw;
            end
        endcase
    end

endmodule

// File: mem_access_fsm.sv
`timescale 1ns/10ps
`include "lsu_config.svh"

module mem_access_fsm
    import lsu_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pipeline_flush,
    input  stage_in_t            stage_in,
    input  op_info_t             info,
    input  logic                 req_ready,
    input  dresp_t               dresp,
    output mem_op_t              eff_op,
    output dreq_t                dreq,
    output logic [`LSU_XLEN-1:0] rdata_held,
    output logic                 memory_unit_stall
);

    typedef enum logic [1:0] {
        WAIT       = 2'd0,
        WAIT_READY = 2'd1,
        WAIT_READ  = 2'd2
    } state_t;

    state_t      state;
    logic [63:0] saved_inst_id;
    logic        executed;
    mem_op_t     replace_op;
    logic        may_start;

    // re-issue guard on the instruction id
    assign may_start = !executed || (saved_inst_id != stage_in.inst_id);

    // second half of a swap runs as a plain word store
    always_comb begin
        if (!stage_in.valid) begin
            eff_op = MEN_X;
        end else if (replace_op != MEN_X && saved_inst_id == stage_in.inst_id) begin
            eff_op = replace_op;
        end else begin
            eff_op = stage_in.ctrl.mem_op;
        end
    end

    assign dreq.valid = stage_in.valid && (state == WAIT_READY);
    assign dreq.wen   = info.is_store;
    assign dreq.addr  = stage_in.alu_out;
    assign dreq.wdata = stage_in.ctrl.rs2_data;
    assign dreq.wmask = info.wmask;

    assign memory_unit_stall = stage_in.valid &&
        ((state != WAIT) || (may_start && eff_op != MEN_X));

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= WAIT;
            executed      <= 1'b0;
            replace_op    <= MEN_X;
            saved_inst_id <= 64'hffff_0000_0000_0000;
        end else begin
            if (stage_in.valid) begin
                saved_inst_id <= stage_in.inst_id;
            end

            if (pipeline_flush || !stage_in.valid) begin
                state      <= WAIT;
                executed   <= 1'b0;
                replace_op <= MEN_X;
            end else begin
                case (state)
                    WAIT: begin
                        if (eff_op != MEN_X && may_start) begin
                            state      <= WAIT_READY;
                            executed   <= 1'b0;
                            replace_op <= MEN_X;
                        end
                    end
                    WAIT_READY: begin
                        if (req_ready) begin
                            if (info.is_store) begin
                                // store is done once the memory takes it
                                state      <= WAIT;
                                executed   <= 1'b1;
                                replace_op <= MEN_X;
                            end else if (info.is_load) begin
                                state <= WAIT_READ;
                            end
                        end
                    end
                    WAIT_READ: begin
                        if (dresp.valid) begin
                            if (info.is_swap) begin
                                state      <= WAIT_READY;
                                replace_op <= MEN_SW;
                            end else begin
                                state    <= WAIT;
                                executed <= 1'b1;
                            end
                        end
                    end
                    default: begin
                        state <= WAIT;
                    end
                endcase
            end
        end
    end

    // read data kept for write-back until the next read returns
    always_ff @(posedge clk) begin
        if (state == WAIT_READ && dresp.valid) begin
            rdata_held <= dresp.rdata;
        end
    end

endmodule

// File: mem_op_decode.sv
`timescale 1ns/10ps

module mem_op_decode
    import lsu_pkg::*;
(
    input  mem_op_t  op,
    output op_info_t info
);

    always_comb begin
        info.is_load  = 1'b0;
        info.is_store = 1'b0;
        info.is_swap  = 1'b0;
        info.wmask    = '1;

        case (op)
            MEN_LB, MEN_LBU, MEN_LH, MEN_LHU, MEN_LW: begin
                info.is_load = 1'b1;
            end
            MEN_SB: begin
                info.is_store = 1'b1;
                // byte lane always at bit 0, not shifted by address
                info.wmask    = 'h0000_00ff;
            end
            MEN_SH: begin
                info.is_store = 1'b1;
                info.wmask    = 'h0000_ffff;
            end
            MEN_SW: begin
                info.is_store = 1'b1;
            end
            MEN_AMOSWAP: begin
                // read half first, the write half comes back as MEN_SW
                info.is_load = 1'b1;
                info.is_swap = 1'b1;
            end
            default: begin
                info.is_load  = 1'b0;
                info.is_store = 1'b0;
            end
        endcase
    end

endmodule

// File: lsu_pkg.sv
`include "lsu_config.svh"

package lsu_pkg;

    // memory operation carried in the control bundle
    typedef enum logic [3:0] {
        MEN_X       = 4'd0,
        MEN_LB      = 4'd1,
        MEN_LBU     = 4'd2,
        MEN_LH      = 4'd3,
        MEN_LHU     = 4'd4,
        MEN_LW      = 4'd5,
        MEN_SB      = 4'd6,
        MEN_SH      = 4'd7,
        MEN_SW      = 4'd8,
        MEN_AMOSWAP = 4'd9
    } mem_op_t;

    typedef struct packed {
        mem_op_t               mem_op;
        logic [`LSU_XLEN-1:0]  rs2_data;
    } mem_ctrl_t;

    // memory-stage input from the execute stage
    typedef struct packed {
        logic                  valid;
        logic [`LSU_XLEN-1:0]  reg_pc;
        logic [`LSU_XLEN-1:0]  inst;
        logic [63:0]           inst_id;
        mem_ctrl_t             ctrl;
        logic [`LSU_XLEN-1:0]  alu_out;
        logic [`LSU_XLEN-1:0]  csr_rdata;
    } stage_in_t;

    typedef struct packed {
        logic                  valid;
        logic                  wen;
        logic [`LSU_XLEN-1:0]  addr;
        logic [`LSU_XLEN-1:0]  wdata;
        logic [`LSU_XLEN-1:0]  wmask;
    } dreq_t;

    typedef struct packed {
        logic                  valid;
        logic [`LSU_XLEN-1:0]  rdata;
    } dresp_t;

    // bundle handed on to write-back
    typedef struct packed {
        logic                  valid;
        logic [`LSU_XLEN-1:0]  reg_pc;
        logic [`LSU_XLEN-1:0]  inst;
        logic [63:0]           inst_id;
        mem_ctrl_t             ctrl;
        logic [`LSU_XLEN-1:0]  alu_out;
        logic [`LSU_XLEN-1:0]  mem_rdata;
        logic [`LSU_XLEN-1:0]  csr_rdata;
    } mem_wb_t;

    typedef struct packed {
        logic                  is_load;
        logic                  is_store;
        logic                  is_swap;
        logic [`LSU_XLEN-1:0]  wmask;
    } op_info_t;

endpackage

// File: lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// data and address width, one machine word
`define LSU_XLEN 32

// data memory depth in words
`define LSU_RAM_WORDS 256

// cycles from an accepted read to its response
`define LSU_RAM_LATENCY 2

`endif
